// File: tests/branch_testdata.txt
# command name, then hex fields: ISSUE id op filled a1 a2 pred dst | CDB tag data | IDLE cycles
# EXPECT id taken miss redirect | FLUSH | END; filled bit 0 is a1, a waiting word holds its tag
ISSUE  blt_taken   1 BLT  f 00000005 00000009 00000001 00000abc
EXPECT blt_taken   1 1 0 abc
ISSUE  blt_not     2 BLT  f ffffffff 00000001 00000001 00012345
EXPECT blt_not     2 0 1 345
ISSUE  beq_eq      3 BEQ  f 00001234 00001234 00000000 00000777
EXPECT beq_eq      3 1 1 777
ISSUE  beq_ne      4 BEQ  f 00000010 00000011 00000000 fffff100
EXPECT beq_ne      4 0 0 100
ISSUE  jmpr        5 JMPR f 0000a5a5 00000000 00000000 00000123
EXPECT jmpr        5 1 1 5a5
ISSUE  jmpr_pred   6 JMPR f 00001ffe 00000000 00000001 00000000
EXPECT jmpr_pred   6 1 1 ffe
IDLE   drain       4
ISSUE  tag_wait    7 BLT  c 00000009 0000000a 00000000 00000200
IDLE   tag_wait    3
CDB    tag_wait    9 00000003
IDLE   tag_wait    1
CDB    tag_wait    a 00000004
IDLE   tag_wait    1
EXPECT tag_wait    7 1 1 200
IDLE   drain       4
CDB    fwd         5 00000001
ISSUE  fwd         8 BEQ  b 00000042 00000042 00000005 00000333
EXPECT fwd         8 1 0 333
IDLE   drain       4
ISSUE  ord_old     9 BEQ  e 00000003 00000050 00000001 00000400
ISSUE  ord_young   a BLT  f 00000001 00000002 00000001 00000500
IDLE   ord         3
CDB    ord_old     3 00000050
IDLE   ord         1
EXPECT ord_old     9 1 0 400
EXPECT ord_young   a 1 0 500
IDLE   drain       4
ISSUE  full_1      1 BLT  e 0000000b 00000002 00000001 00000601
EXPECT full_1      1 1 0 601
ISSUE  full_2      2 BEQ  e 0000000b 00000001 00000000 00000602
EXPECT full_2      2 1 1 602
ISSUE  full_3      3 BLT  e 0000000b 00000001 00000000 00000603
EXPECT full_3      3 0 0 603
ISSUE  full_4      4 JMPR e 0000000b 00000000 00000000 00000604
EXPECT full_4      4 1 1 001
CDB    full_free   b 00000001
ISSUE  full_5      5 BEQ  f 00000007 00000008 00000001 00000605
EXPECT full_5      5 0 1 605
IDLE   drain       8
ISSUE  flush_a     6 BLT  e 0000000c 00000001 00000000 00000700
ISSUE  flush_b     7 BEQ  f 00000001 00000001 00000001 00000701
IDLE   flush       2
FLUSH  flush
IDLE   flush       2
CDB    flush_late  c 00000000
IDLE   flush       3
ISSUE  flush_fly   9 BLT  f 00000001 00000002 00000001 00000702
FLUSH  flush_fly
IDLE   flush_fly   3
ISSUE  after_flush 8 BEQ  f 00000005 00000005 00000001 00000abc
EXPECT after_flush 8 1 0 abc
IDLE   drain       4
END    done

// File: branch_unit.f
+incdir+source
source/isa_pkg.sv
source/ooo_pkg.sv
source/rs_dispatch_if.sv
source/reservation_station.sv
source/branch_resolve.sv
source/branch_unit_top.sv
tests/tb_clock_gen.sv
tests/branch_unit_tb.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := branch_unit_tb
FILELIST  := branch_unit.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(filter-out +incdir+%,$(shell cat $(FILELIST)))
HEADERS   := $(wildcard source/*.svh)

.PHONY: all run clean

all: $(SIM_BIN)

# rebuilt only when a source, a header or the file list changes
$(SIM_BIN): $(SOURCES) $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the pass line in the log decides the exit status
run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -q "^Simulation completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tests/branch_unit_tb.sv
`timescale 1ns/1ns
`include "fcpu_macros.svh"

module branch_unit_tb
   import isa_pkg::*, ooo_pkg::*;
();

   localparam string DATA_FILE = "tests/branch_testdata.txt";

   logic                    clk;
   logic                    nrst;
   logic                    i_flush;
   logic                    i_valid;
   tag_t                    i_id;
   opcode_t                 i_opcode;
   logic [`N_OPERANDS-1:0]  i_filled;
   logic [`DATA_W-1:0]      i_a1;
   logic [`DATA_W-1:0]      i_a2;
   logic [`DATA_W-1:0]      i_pred;
   logic [`DATA_W-1:0]      i_dst;
   logic                    o_ready;
   logic                    i_cdb_valid;
   tag_t                    i_cdb_tag;
   logic [`DATA_W-1:0]      i_cdb_data;
   logic                    o_resolve_valid;
   tag_t                    o_resolve_id;
   logic                    o_taken;
   logic                    o_pred_miss;
   logic [`CRAM_ADDR_W-1:0] o_redirect_addr;

   // expected results in issue order
   string                   exp_name[$];
   tag_t                    exp_id[$];
   logic                    exp_taken[$];
   logic                    exp_miss[$];
   logic [`CRAM_ADDR_W-1:0] exp_addr[$];
   string                   lines[$];
   string                   cur_test = "reset";
   int                      in_station = 0;   // accepted branches not yet resolved or flushed
   int                      mismatches = 0;
   int                      other_errors = 0;
   int                      cycles = 0;
   int                      cycle_limit = 0;

   tb_clock_gen i_tb_clock_gen (.clk(clk), .nrst(nrst));

   branch_unit_top i_branch_unit_top (
      .clk(clk), .nrst(nrst), .i_flush(i_flush),
      .i_valid(i_valid), .i_id(i_id), .i_opcode(i_opcode), .i_filled(i_filled),
      .i_a1(i_a1), .i_a2(i_a2), .i_pred(i_pred), .i_dst(i_dst), .o_ready(o_ready),
      .i_cdb_valid(i_cdb_valid), .i_cdb_tag(i_cdb_tag), .i_cdb_data(i_cdb_data),
      .o_resolve_valid(o_resolve_valid), .o_resolve_id(o_resolve_id), .o_taken(o_taken),
      .o_pred_miss(o_pred_miss), .o_redirect_addr(o_redirect_addr)
   );

   task automatic check_tag(input string test, input string what, input tag_t exp,
                            input tag_t act);
      if (act !== exp) begin
         $display("MISMATCH %s %s expected %h actual %h", test, what, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_flag(input string test, input string what, input logic exp,
                             input logic act);
      if (act !== exp) begin
         $display("MISMATCH %s %s expected %b actual %b", test, what, exp, act);
         mismatches++;
      end
   endtask

   task automatic check_addr(input string test, input string what,
                             input logic [`CRAM_ADDR_W-1:0] exp,
                             input logic [`CRAM_ADDR_W-1:0] act);
      if (act !== exp) begin
         $display("MISMATCH %s %s expected %h actual %h", test, what, exp, act);
         mismatches++;
      end
   endtask

   function automatic opcode_t opcode_from_name(input string s);
      case (s)
         "NOP":   return I_NOP;
         "BLT":   return I_BLT;
         "BEQ":   return I_BEQ;
         "JMPR":  return I_JMPR;
         default: begin
            $display("unknown opcode %s in the test data", s);
            other_errors++;
            return I_NOP;
         end
      endcase
   endfunction

   // a CDB or flush pulse lasts for exactly one edge
   task automatic step_cycle();
      @(posedge clk);
      #2;
      i_cdb_valid = 1'b0;
      i_flush     = 1'b0;
   endtask

   task automatic issue_branch(input tag_t id, input opcode_t op,
                               input logic [`N_OPERANDS-1:0] filled,
                               input logic [`DATA_W-1:0] a1, input logic [`DATA_W-1:0] a2,
                               input logic [`DATA_W-1:0] pred,
                               input logic [`DATA_W-1:0] dst);
      logic accepted;
      i_valid  = 1'b1;
      i_id     = id;
      i_opcode = op;
      i_filled = filled;
      i_a1     = a1;
      i_a2     = a2;
      i_pred   = pred;
      i_dst    = dst;
      do begin
         @(negedge clk);
         accepted = o_ready;   // o_ready only moves on clock edges
         step_cycle();
      end while (!accepted);
      i_valid = 1'b0;
      in_station++;
   endtask

   initial begin
      int               fd;
      logic [8*160-1:0] raw;
      logic [8*16-1:0]  cmd_v;
      logic [8*16-1:0]  name_v;
      logic [8*16-1:0]  op_v;
      logic [31:0]      f1;
      logic [31:0]      f2;
      logic [31:0]      f3;
      logic [31:0]      f4;
      logic [31:0]      f5;
      logic [31:0]      f6;
      string            cmd;
      string            name;
      string            line;
      bit               finished;
      i_flush     = 1'b0;
      i_valid     = 1'b0;
      i_id        = '0;
      i_opcode    = I_NOP;
      i_filled    = '0;
      i_a1        = '0;
      i_a2        = '0;
      i_pred      = '0;
      i_dst       = '0;
      i_cdb_valid = 1'b0;
      i_cdb_tag   = '0;
      i_cdb_data  = '0;
      finished    = 1'b0;
      fd = $fopen(DATA_FILE, "r");
      if (fd == 0) begin
         $display("cannot open the test data file %s", DATA_FILE);
         other_errors++;
      end else begin
         while (!$feof(fd)) begin
            raw = '0;
            if ($fgets(raw, fd) != 0) begin
               line = string'(raw);
               if (line.len() > 1 && line.getc(0) != "#") begin
                  lines.push_back(line);
               end
            end
         end
         $fclose(fd);
      end
      cycle_limit = 16 * lines.size() + 200;

      @(negedge nrst);
      @(negedge clk);
      if (o_ready !== 1'b1 || o_resolve_valid !== 1'b0) begin
         $display("after reset the cluster is not empty and idle");
         other_errors++;
      end
      step_cycle();

      for (int n = 0; n < lines.size() && !finished; n++) begin
         void'($sscanf(lines[n], "%s %s", cmd_v, name_v));
         cmd      = string'(cmd_v);
         name     = string'(name_v);
         cur_test = name;
         case (cmd)
            "ISSUE": begin
               void'($sscanf(lines[n], "%s %s %h %s %h %h %h %h %h",
                             cmd_v, name_v, f1, op_v, f2, f3, f4, f5, f6));
               issue_branch(f1[`TAG_W-1:0], opcode_from_name(string'(op_v)),
                            f2[`N_OPERANDS-1:0], f3, f4, f5, f6);
            end
            "CDB": begin
               void'($sscanf(lines[n], "%s %s %h %h", cmd_v, name_v, f1, f2));
               i_cdb_valid = 1'b1;   // goes out with the next edge of any command
               i_cdb_tag   = f1[`TAG_W-1:0];
               i_cdb_data  = f2;
            end
            "FLUSH": begin
               i_flush = 1'b1;
               step_cycle();
               in_station = 0;
            end
            "IDLE": begin
               void'($sscanf(lines[n], "%s %s %d", cmd_v, name_v, f1));
               repeat (f1) step_cycle();
            end
            "EXPECT": begin
               void'($sscanf(lines[n], "%s %s %h %h %h %h", cmd_v, name_v, f1, f2, f3, f4));
               exp_name.push_back(name);
               exp_id.push_back(f1[`TAG_W-1:0]);
               exp_taken.push_back(f2[0]);
               exp_miss.push_back(f3[0]);
               exp_addr.push_back(f4[`CRAM_ADDR_W-1:0]);
            end
            "END": finished = 1'b1;
            default: begin
               $display("unknown command %s in the test data", cmd);
               other_errors++;
            end
         endcase
      end

      if (!finished) begin
         $display("the test data ended without an END line");
         other_errors++;
      end
      if (exp_id.size() != 0) begin
         $display("%0d expected results never arrived, the first one from test %s",
                  exp_id.size(), exp_name[0]);
         other_errors += exp_id.size();
      end
      $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

   // results are sampled mid-cycle away from the clock edges
   always @(negedge clk) begin : result_monitor
      string test;
      if (!nrst && o_resolve_valid === 1'b1) begin
         in_station--;
         if (exp_id.size() == 0) begin
            $display("result for id %h arrived while no result was expected", o_resolve_id);
            other_errors++;
         end else begin
            test = exp_name.pop_front();
            check_tag(test, "id", exp_id.pop_front(), o_resolve_id);
            check_flag(test, "taken", exp_taken.pop_front(), o_taken);
            check_flag(test, "miss", exp_miss.pop_front(), o_pred_miss);
            check_addr(test, "redirect", exp_addr.pop_front(), o_redirect_addr);
         end
      end else if (!nrst && o_resolve_valid !== 1'b0) begin
         $display("o_resolve_valid is unknown after reset");
         other_errors++;
      end
      // the station has a free slot unless every slot holds an unresolved branch
      if (!nrst) begin
         check_flag(cur_test, "ready", in_station < `N_STATIONS, o_ready);
      end
   end

   always @(posedge clk) begin
      cycles++;
      if (cycle_limit > 0 && cycles >= cycle_limit) begin
         $display("timeout after %0d cycles, the test data did not run to its end", cycles);
         $display("errors: %0d mismatches, %0d other failures", mismatches, other_errors);
         $display("Simulation failed");
         $finish;
      end
   end

endmodule

// File: tests/tb_clock_gen.sv
`timescale 1ns/1ns

module tb_clock_gen #(
   parameter int PERIOD_NS    = 20,
   parameter int RESET_CYCLES = 10
) (
   output logic clk,
   output logic nrst
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2) clk = ~clk;
   end

   // reset is active high and drops just after a rising edge as the other inputs do
   initial begin
      nrst = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      #2 nrst = 1'b0;
   end

endmodule

// File: source/branch_unit_top.sv
`timescale 1ns/1ns
`include "fcpu_macros.svh"

module branch_unit_top
   import isa_pkg::*, ooo_pkg::*;
(
   input  logic                     clk,
   input  logic                     nrst,
   input  logic                     i_flush,
   input  logic                     i_valid,
   input  tag_t                     i_id,
   input  opcode_t                  i_opcode,
   input  logic [`N_OPERANDS-1:0]   i_filled,
   input  logic [`DATA_W-1:0]       i_a1,
   input  logic [`DATA_W-1:0]       i_a2,
   input  logic [`DATA_W-1:0]       i_pred,
   input  logic [`DATA_W-1:0]       i_dst,
   output logic                     o_ready,
   input  logic                     i_cdb_valid,
   input  tag_t                     i_cdb_tag,
   input  logic [`DATA_W-1:0]       i_cdb_data,
   output logic                     o_resolve_valid,
   output tag_t                     o_resolve_id,
   output logic                     o_taken,
   output logic                     o_pred_miss,
   output logic [`CRAM_ADDR_W-1:0]  o_redirect_addr
);

   br_entry_t issue_entry;

   // unfilled operand words carry the producer tag in their low bits
   assign issue_entry.id                  = i_id;
   assign issue_entry.opcode              = i_opcode;
   assign issue_entry.filled              = i_filled;
   assign issue_entry.ops[OP_A1].value    = i_a1;
   assign issue_entry.ops[OP_A2].value    = i_a2;
   assign issue_entry.ops[OP_PRED].value  = i_pred;
   assign issue_entry.ops[OP_DST].value   = i_dst;

   rs_dispatch_if dsp_if ();

   reservation_station i_reservation_station (
      .clk         (clk),
      .nrst        (nrst),
      .i_flush     (i_flush),
      .i_valid     (i_valid),
      .i_entry     (issue_entry),
      .o_ready     (o_ready),
      .i_cdb_valid (i_cdb_valid),
      .i_cdb_tag   (i_cdb_tag),
      .i_cdb_data  (i_cdb_data),
      .dsp         (dsp_if.station)
   );

   branch_resolve i_branch_resolve (
      .clk             (clk),
      .nrst            (nrst),
      .i_flush         (i_flush),
      .dsp             (dsp_if.resolver),
      .o_resolve_valid (o_resolve_valid),
      .o_resolve_id    (o_resolve_id),
      .o_taken         (o_taken),
      .o_pred_miss     (o_pred_miss),
      .o_redirect_addr (o_redirect_addr)
   );

endmodule

// File: source/branch_resolve.sv
`timescale 1ns/1ns
`include "fcpu_macros.svh"

module branch_resolve
   import isa_pkg::*, ooo_pkg::*;
(
   input  logic                     clk,
   input  logic                     nrst,
   input  logic                     i_flush,
   rs_dispatch_if.resolver          dsp,
   output logic                     o_resolve_valid,
   output tag_t                     o_resolve_id,
   output logic                     o_taken,
   output logic                     o_pred_miss,
   output logic [`CRAM_ADDR_W-1:0]  o_redirect_addr
);

   logic                    r_valid;
   tag_t                    r_id;
   opcode_t                 r_opcode;
   ops_t                    r_ops;
   logic                    taken;
   logic                    miss;
   logic [`CRAM_ADDR_W-1:0] redirect;

   assign dsp.ready = 1'b1;   // takes one branch every cycle and never stalls

   always_ff @(posedge clk) begin
      if (nrst || i_flush) begin
         r_valid <= 1'b0;   // a flushed result never shows up
      end else begin
         r_valid <= dsp.valid && dsp.ready;
      end
   end

   always_ff @(posedge clk) begin
      if (dsp.valid && dsp.ready) begin
         r_id     <= dsp.id;
         r_opcode <= dsp.opcode;
         r_ops    <= dsp.ops;
      end
   end

   always_comb begin
      taken    = 1'b0;
      miss     = 1'b0;
      redirect = r_ops[OP_DST].value[`CRAM_ADDR_W-1:0];
      case (r_opcode)
         I_BLT: begin
            taken = (r_ops[OP_A1].value < r_ops[OP_A2].value);
            miss  = taken ^ r_ops[OP_PRED].value[0];
         end
         I_BEQ: begin
            taken = (r_ops[OP_A1].value == r_ops[OP_A2].value);
            miss  = taken ^ r_ops[OP_PRED].value[0];
         end
         I_JMPR: begin
            // the target is only known here, so the front end always has to follow
            taken    = 1'b1;
            miss     = 1'b1;
            redirect = r_ops[OP_A1].value[`CRAM_ADDR_W-1:0];
         end
         default: ;
      endcase
   end

   assign o_resolve_valid = r_valid;
   assign o_resolve_id    = r_id;
   assign o_taken         = r_valid && taken;
   assign o_pred_miss     = r_valid && miss;
   assign o_redirect_addr = redirect;

endmodule

// File: source/reservation_station.sv
`timescale 1ns/1ns
`include "fcpu_macros.svh"

module reservation_station
   import isa_pkg::*, ooo_pkg::*;
(
   input  logic                 clk,
   input  logic                 nrst,
   input  logic                 i_flush,
   input  logic                 i_valid,
   input  br_entry_t            i_entry,
   output logic                 o_ready,
   input  logic                 i_cdb_valid,
   input  tag_t                 i_cdb_tag,
   input  logic [`DATA_W-1:0]   i_cdb_data,
   rs_dispatch_if.station       dsp
);

   localparam int PTR_W = $clog2(`N_STATIONS);
   localparam int CNT_W = $clog2(`N_STATIONS + 1);

   br_entry_t        slots [`N_STATIONS];
   br_entry_t        issue_fwd;
   logic [PTR_W-1:0] head;
   logic [PTR_W-1:0] tail;
   logic [CNT_W-1:0] count;
   logic             issue_fire;
   logic             disp_fire;

   // replace every waiting operand whose producer is on the CDB this cycle
   function automatic br_entry_t snoop(
      input br_entry_t          e,
      input logic               cdb_valid,
      input tag_t               cdb_tag,
      input logic [`DATA_W-1:0] cdb_data
   );
      br_entry_t r;
      r = e;
      for (int j = 0; j < `N_OPERANDS; j++) begin
         if (cdb_valid && !e.filled[j] && e.ops[j].wait_tag.tag == cdb_tag) begin
            r.ops[j].value = cdb_data;
            r.filled[j]    = 1'b1;
         end
      end
      return r;
   endfunction

   function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] p);
      if (p == PTR_W'(`N_STATIONS - 1)) begin
         return '0;
      end
      return p + 1'b1;
   endfunction

   assign o_ready    = (count != CNT_W'(`N_STATIONS));
   assign issue_fire = i_valid && o_ready && !i_flush;   // flush wins over an issue
   assign disp_fire  = dsp.valid && dsp.ready;

   // an operand broadcast in the issue cycle is stored already filled
   assign issue_fwd = snoop(i_entry, i_cdb_valid, i_cdb_tag, i_cdb_data);

   // branches leave in program order so only the oldest entry is offered
   assign dsp.valid  = (count != '0) && (&slots[head].filled);
   assign dsp.id     = slots[head].id;
   assign dsp.opcode = slots[head].opcode;
   assign dsp.ops    = slots[head].ops;

   always_ff @(posedge clk) begin
      if (nrst || i_flush) begin
         head  <= '0;
         tail  <= '0;
         count <= '0;
      end else begin
         if (issue_fire) begin
            tail <= next_ptr(tail);
         end
         if (disp_fire) begin
            head <= next_ptr(head);
         end
         case ({issue_fire, disp_fire})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;     // both or neither leaves the fill level alone
         endcase
      end
   end

   always_ff @(posedge clk) begin
      for (int i = 0; i < `N_STATIONS; i++) begin
         slots[i] <= snoop(slots[i], i_cdb_valid, i_cdb_tag, i_cdb_data);
      end
      if (issue_fire) begin
         slots[tail] <= issue_fwd;   // overrides the snoop of a stale slot
      end
   end

endmodule

// File: source/rs_dispatch_if.sv
`timescale 1ns/1ns

interface rs_dispatch_if
   import isa_pkg::*, ooo_pkg::*;
();

   logic    valid;
   logic    ready;
   tag_t    id;
   opcode_t opcode;
   ops_t    ops;      // every operand is filled when valid is high

   modport station (
      output valid, id, opcode, ops,
      input  ready
   );

   modport resolver (
      input  valid, id, opcode, ops,
      output ready
   );

endinterface

// File: source/ooo_pkg.sv
`include "fcpu_macros.svh"

package ooo_pkg;

   import isa_pkg::*;

   typedef logic [`TAG_W-1:0] tag_t;

   // operand slot positions inside an entry
   localparam int OP_A1   = 0;
   localparam int OP_A2   = 1;
   localparam int OP_PRED = 2;   // bit 0 is the predicted outcome
   localparam int OP_DST  = 3;   // fall-back address if the prediction is wrong

   // a waiting operand holds its producer tag in the low bits,
   // a filled one holds the value itself
   typedef union packed {
      logic [`DATA_W-1:0] value;
      struct packed {
         logic [`DATA_W-`TAG_W-1:0] pad;
         tag_t                      tag;
      } wait_tag;
   } operand_u;

   typedef operand_u [`N_OPERANDS-1:0] ops_t;

   typedef struct packed {
      tag_t                   id;       // the branch's own tag
      opcode_t                opcode;
      logic [`N_OPERANDS-1:0] filled;   // one bit per operand
      ops_t                   ops;
   } br_entry_t;

endpackage

// File: source/isa_pkg.sv
`include "fcpu_macros.svh"

package isa_pkg;

   // branch class opcodes seen by the branch cluster
   typedef enum logic [2:0] {
      I_NOP  = 3'd0,
      I_BLT  = 3'd1,   // taken when a1 < a2 as unsigned values
      I_BEQ  = 3'd2,   // taken when a1 == a2
      I_JMPR = 3'd3    // unconditional jump to a1
   } opcode_t;

endpackage

// File: source/fcpu_macros.svh
`ifndef FCPU_MACROS_SVH
`define FCPU_MACROS_SVH

// operand and result data width
`define DATA_W 32

// tag naming the in-flight instruction that produces a value
`define TAG_W 4

// code RAM address width, used for redirect targets
`define CRAM_ADDR_W 12

// branch reservation station depth
`define N_STATIONS 4

// a1, a2, pred and dst
`define N_OPERANDS 4

`endif
